/* project.f */
+incdir+source
source/ccip_hdr_pkg.sv
source/sniff_code_pkg.sv
source/ccip_sniffer.sv
source/c0_read_checker.sv
source/c1_write_checker.sv
source/mmio_tid_dispatch.sv
source/mmio_tid_tracker.sv
source/sniff_error_encoder.sv
verification/ccip_sniffer_chk.sv
verification/ccip_sniffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sniffer testbench, exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module ccip_sniffer_tb -o ccip_sniffer_sim &&
./obj_dir/ccip_sniffer_sim ||
{ echo "simulation run failed"; exit 1; }

/* source/c0_read_checker.sv */
//####################
// C0 read checker
// Per-beat rule checks on read requests
//####################

`timescale 1ns/1ps
`default_nettype none

module c0_read_checker (
   c0_tx_if.check tx,
   output sniff_code_pkg::c0_flags_t flags
);

   import ccip_hdr_pkg::*;

   logic is_read;
   logic rd_beat;

   assign is_read = is_read_req(tx.req_type);
   assign rd_beat = tx.valid && is_read;

   always_comb begin
      flags = '0;

      // Anything but a read line on C0
      flags.invalid_reqtype = tx.valid && !is_read;

      // Full is only watched, the beat still counts
      flags.overflow = tx.valid && tx.full;

      // Length checks only make sense on a real read
      if (rd_beat) begin
         flags.req_3cl = (tx.cl_len == CL_LEN_3);

         // 2-line burst on an even line
         flags.addralign_2 = (tx.cl_len == CL_LEN_2) && tx.address[0];

         // 4-line burst on a 4-line boundary
         flags.addralign_4 = (tx.cl_len == CL_LEN_4) &&
                             (tx.address[1:0] != 2'b00);
      end
   end

endmodule

`default_nettype wire

/* source/c1_write_checker.sv */
//####################
// C1 write checker
// Tracks multi-line write bursts and checks every write beat
// against the SOP beat of its burst
//####################

`timescale 1ns/1ps
`default_nettype none

module c1_write_checker (
   input  logic clk,
   input  logic rst_n,
   c1_tx_if.check tx,
   output sniff_code_pkg::c1_flags_t flags
);

   import ccip_hdr_pkg::*;

   // State value is also the beat index inside the burst
   typedef enum logic [1:0] {
      ST_FIRST = 2'd0,
      ST_BEAT2 = 2'd1,
      ST_BEAT3 = 2'd2,
      ST_BEAT4 = 2'd3
   } c1_state_t;

   c1_state_t state;
   c1_state_t state_nxt;

   // Fields of the SOP beat
   logic [1:0]   base_addr_low2;
   t_ccip_vc     base_vc;
   t_ccip_req    base_req;
   t_ccip_cl_len base_len;

   logic       is_wr;
   logic       is_fence;
   logic       wr_beat;
   logic       fence_beat;
   logic       start_burst;
   logic [1:0] exp_addr_low2;

   assign is_wr       = is_write_req(tx.req_type);
   assign is_fence    = (tx.req_type == WRFENCE);
   assign wr_beat     = tx.valid && is_wr;
   assign fence_beat  = tx.valid && is_fence;
   assign start_burst = (state == ST_FIRST) && wr_beat && tx.sop &&
                        (tx.cl_len inside {CL_LEN_2, CL_LEN_4});

   // Base line plus beat index, wraps in two bits
   assign exp_addr_low2 = base_addr_low2 + state;

   always_comb begin
      flags = '0;
      flags.invalid_reqtype = tx.valid && !is_wr && !is_fence;
      flags.overflow        = tx.valid && tx.full;

      if (state == ST_FIRST) begin
         // Opening beat of a burst or a lone write
         if (wr_beat) begin
            flags.sop_not_set = !tx.sop;
            flags.req_3cl     = (tx.cl_len == CL_LEN_3);
            flags.addralign_2 = (tx.cl_len == CL_LEN_2) && tx.address[0];
            flags.addralign_4 = (tx.cl_len == CL_LEN_4) &&
                                (tx.address[1:0] != 2'b00);
         end
      end else begin
         // Follow-on beats must match the SOP beat
         if (wr_beat) begin
            flags.sop_set_mcl   = tx.sop;
            flags.unexp_vcsel   = (tx.vc_sel != base_vc);
            flags.unexp_reqtype = (tx.req_type != base_req);
            flags.unexp_addr    = (tx.address[1:0] != exp_addr_low2);
         end
         flags.wrfence_in_mcl = fence_beat;
      end
   end

   // Only write beats move the burst along
   always_comb begin
      state_nxt = state;
      case (state)
         ST_FIRST: if (start_burst) state_nxt = ST_BEAT2;
         ST_BEAT2: begin
            if (wr_beat) begin
               state_nxt = (base_len == CL_LEN_2) ? ST_FIRST : ST_BEAT3;
            end
         end
         ST_BEAT3: if (wr_beat) state_nxt = ST_BEAT4;
         default:  if (wr_beat) state_nxt = ST_FIRST;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_FIRST;
      end else begin
         state <= state_nxt;
      end
   end

   // Snapshot at the SOP beat
   always_ff @(posedge clk) begin
      if (start_burst) begin
         base_addr_low2 <= tx.address[1:0];
         base_vc        <= tx.vc_sel;
         base_req       <= tx.req_type;
         base_len       <= tx.cl_len;
      end
   end

endmodule

`default_nettype wire

/* source/ccip_hdr_pkg.sv */
//####################
// CCI-P header fields
// Request type, line length, VC select and address types
//####################

`default_nettype none

`include "ccip_sniff_macros.svh"

package ccip_hdr_pkg;

   // One encoding space for both request channels
   typedef enum logic [3:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRFENCE  = 4'h4,
      RDLINE_I = 4'h8,
      RDLINE_S = 4'h9
   } t_ccip_req;

   // Encoded as lines minus one
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'b00,
      CL_LEN_2 = 2'b01,
      CL_LEN_3 = 2'b10,
      CL_LEN_4 = 2'b11
   } t_ccip_cl_len;

   typedef enum logic [1:0] {
      VC_VA  = 2'b00,
      VC_VL0 = 2'b01,
      VC_VH0 = 2'b10,
      VC_VH1 = 2'b11
   } t_ccip_vc;

   typedef logic [`CCIP_ADDR_WIDTH-1:0] t_ccip_addr;

   // Legal C0 request
   function automatic logic is_read_req(t_ccip_req req);
      return req inside {RDLINE_S, RDLINE_I};
   endfunction

   // Data-carrying C1 request, fences excluded
   function automatic logic is_write_req(t_ccip_req req);
      return req inside {WRLINE_M, WRLINE_I};
   endfunction

endpackage

`default_nettype wire

/* source/ccip_sniff_macros.svh */
//####################
// CCI-P sniffer sizing
// TID space, cache-line address width and the MMIO response
// timeout shared by the sniffer blocks
//####################

`ifndef CCIP_SNIFF_MACROS_SVH
`define CCIP_SNIFF_MACROS_SVH

// MMIO transaction id, one tracker slot per value
`define CCIP_TID_WIDTH 4
`define CCIP_NUM_TIDS (1 << `CCIP_TID_WIDTH)

// Cache-line granular address
`define CCIP_ADDR_WIDTH 42

// Cycles an MMIO read may stay open before it times out
`define MMIO_RSP_TIMEOUT 64
// Must hold MMIO_RSP_TIMEOUT itself
`define MMIO_TIMER_WIDTH 7

`endif

/* source/ccip_sniffer.sv */
//####################
// CCI-P sniffer top
// Channel interfaces, rule checkers, MMIO slot trackers and the
// error encoder
//####################

`timescale 1ns/1ps
`default_nettype none

`include "ccip_sniff_macros.svh"

// Read request channel
interface c0_tx_if;
   import ccip_hdr_pkg::*;
   logic         valid;
   t_ccip_req    req_type;
   t_ccip_cl_len cl_len;
   t_ccip_addr   address;
   logic         full;
   modport check  (input  valid, req_type, cl_len, address, full);
   modport source (output valid, req_type, cl_len, address, full);
endinterface

// Write request channel, adds SOP and VC
interface c1_tx_if;
   import ccip_hdr_pkg::*;
   logic         valid;
   logic         sop;
   t_ccip_req    req_type;
   t_ccip_cl_len cl_len;
   t_ccip_vc     vc_sel;
   t_ccip_addr   address;
   logic         full;
   modport check  (input  valid, sop, req_type, cl_len, vc_sel, address, full);
   modport source (output valid, sop, req_type, cl_len, vc_sel, address, full);
endinterface

module ccip_sniffer (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          c0_valid,
   input  ccip_hdr_pkg::t_ccip_req       c0_req_type,
   input  ccip_hdr_pkg::t_ccip_cl_len    c0_cl_len,
   input  ccip_hdr_pkg::t_ccip_addr      c0_address,
   input  logic                          c0_full,
   input  logic                          c1_valid,
   input  logic                          c1_sop,
   input  ccip_hdr_pkg::t_ccip_req       c1_req_type,
   input  ccip_hdr_pkg::t_ccip_cl_len    c1_cl_len,
   input  ccip_hdr_pkg::t_ccip_vc        c1_vc_sel,
   input  ccip_hdr_pkg::t_ccip_addr      c1_address,
   input  logic                          c1_full,
   input  logic                          mmio_req_valid,
   input  logic [`CCIP_TID_WIDTH-1:0]    mmio_req_tid,
   input  logic                          mmio_rsp_valid,
   input  logic [`CCIP_TID_WIDTH-1:0]    mmio_rsp_tid,
   output logic                          error_valid,
   output sniff_code_pkg::sniff_code_t   error_code
);

   import sniff_code_pkg::*;

   c0_flags_t                        c0_flags;
   c1_flags_t                        c1_flags;
   logic [`CCIP_NUM_TIDS-1:0]        push;
   logic [`CCIP_NUM_TIDS-1:0]        pop;
   logic [`CCIP_NUM_TIDS-1:0]        timeout;
   logic [`CCIP_NUM_TIDS-1:0]        unsolicited;

   c0_tx_if c0_if ();
   c1_tx_if c1_if ();

   // Plain ports onto the channel bundles
   assign c0_if.valid    = c0_valid;
   assign c0_if.req_type = c0_req_type;
   assign c0_if.cl_len   = c0_cl_len;
   assign c0_if.address  = c0_address;
   assign c0_if.full     = c0_full;
   assign c1_if.valid    = c1_valid;
   assign c1_if.sop      = c1_sop;
   assign c1_if.req_type = c1_req_type;
   assign c1_if.cl_len   = c1_cl_len;
   assign c1_if.vc_sel   = c1_vc_sel;
   assign c1_if.address  = c1_address;
   assign c1_if.full     = c1_full;

   c0_read_checker u_c0_chk (.tx(c0_if), .flags(c0_flags));

   c1_write_checker u_c1_chk (.clk, .rst_n, .tx(c1_if), .flags(c1_flags));

   mmio_tid_dispatch u_dispatch (
      .mmio_req_valid, .mmio_req_tid, .mmio_rsp_valid, .mmio_rsp_tid, .push, .pop
   );

   // One slot per TID
   for (genvar i = 0; i < `CCIP_NUM_TIDS; i++) begin : g_slot
      mmio_tid_tracker u_trk (
         .clk, .rst_n, .push(push[i]), .pop(pop[i]),
         .timeout(timeout[i]), .unsolicited(unsolicited[i])
      );
   end

   sniff_error_encoder u_enc (
      .clk, .rst_n, .c0_flags, .c1_flags, .timeout, .unsolicited,
      .error_valid, .error_code
   );

endmodule

`default_nettype wire

/* source/mmio_tid_dispatch.sv */
//####################
// MMIO TID dispatch
// Turns request and response TIDs into one-hot slot strobes
//####################

`timescale 1ns/1ps
`default_nettype none

`include "ccip_sniff_macros.svh"

module mmio_tid_dispatch (
   input  logic                          mmio_req_valid,
   input  logic [`CCIP_TID_WIDTH-1:0]    mmio_req_tid,
   input  logic                          mmio_rsp_valid,
   input  logic [`CCIP_TID_WIDTH-1:0]    mmio_rsp_tid,
   output logic [`CCIP_NUM_TIDS-1:0]     push,
   output logic [`CCIP_NUM_TIDS-1:0]     pop
);

   always_comb begin
      push = '0;
      pop  = '0;

      // Request opens its slot
      if (mmio_req_valid) push[mmio_req_tid] = 1'b1;

      // Response closes its slot
      if (mmio_rsp_valid) pop[mmio_rsp_tid] = 1'b1;
   end

endmodule

`default_nettype wire

/* source/mmio_tid_tracker.sv */
//####################
// MMIO TID tracker
// One outstanding-read slot with a response timer
//####################

`timescale 1ns/1ps
`default_nettype none

`include "ccip_sniff_macros.svh"

module mmio_tid_tracker (
   input  logic clk,
   input  logic rst_n,
   input  logic push,
   input  logic pop,
   output logic timeout,
   output logic unsolicited
);

   logic                         active;
   logic                         fired;
   logic [`MMIO_TIMER_WIDTH-1:0] timer;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active <= 1'b0;
         fired  <= 1'b0;
         timer  <= '0;
      end else if (push) begin
         // New request restarts the slot, even over a pop
         active <= 1'b1;
         fired  <= 1'b0;
         timer  <= '0;
      end else begin
         if (pop) active <= 1'b0;
         if (timeout) fired <= 1'b1;
         // Saturates at the limit
         if (active && (timer < `MMIO_RSP_TIMEOUT)) timer <= timer + 1'b1;
      end
   end

   // Single pulse at the limit, slot stays open
   assign timeout = active && !fired && (timer == `MMIO_RSP_TIMEOUT);

   // Response with nothing outstanding
   assign unsolicited = pop && !active;

endmodule

`default_nettype wire

/* source/sniff_code_pkg.sv */
//####################
// Sniffer error codes
// Reported codes in priority order and the per-channel flag sets
//####################

`default_nettype none

package sniff_code_pkg;

   // Lower value wins when several rules break together
   typedef enum logic [4:0] {
      SNIFF_NO_ERROR         = 5'd0,
      C0_INVALID_REQTYPE     = 5'd1,
      C0_OVERFLOW            = 5'd2,
      C0_3CL_REQUEST         = 5'd3,
      C0_ADDRALIGN_2         = 5'd4,
      C0_ADDRALIGN_4         = 5'd5,
      C1_INVALID_REQTYPE     = 5'd6,
      C1_OVERFLOW            = 5'd7,
      C1_3CL_REQUEST         = 5'd8,
      C1_SOP_NOT_SET         = 5'd9,
      C1_ADDRALIGN_2         = 5'd10,
      C1_ADDRALIGN_4         = 5'd11,
      C1_SOP_SET_MCL         = 5'd12,
      C1_UNEXP_VCSEL         = 5'd13,
      C1_UNEXP_REQTYPE       = 5'd14,
      C1_UNEXP_ADDR          = 5'd15,
      C1_WRFENCE_IN_MCL      = 5'd16,
      MMIO_RDRSP_UNSOLICITED = 5'd17,
      MMIO_RDRSP_TIMEOUT     = 5'd18
   } sniff_code_t;

   // Read channel rule hits
   typedef struct packed {
      logic invalid_reqtype;
      logic overflow;
      logic req_3cl;
      logic addralign_2;
      logic addralign_4;
   } c0_flags_t;

   // Write channel rule hits, same order as the codes
   typedef struct packed {
      logic invalid_reqtype;
      logic overflow;
      logic req_3cl;
      logic sop_not_set;
      logic addralign_2;
      logic addralign_4;
      logic sop_set_mcl;
      logic unexp_vcsel;
      logic unexp_reqtype;
      logic unexp_addr;
      logic wrfence_in_mcl;
   } c1_flags_t;

endpackage

`default_nettype wire

/* source/sniff_error_encoder.sv */
//####################
// Sniffer error encoder
// Priority pick over all rule flags, one register stage
//####################

`timescale 1ns/1ps
`default_nettype none

`include "ccip_sniff_macros.svh"

module sniff_error_encoder (
   input  logic                             clk,
   input  logic                             rst_n,
   input  sniff_code_pkg::c0_flags_t        c0_flags,
   input  sniff_code_pkg::c1_flags_t        c1_flags,
   input  logic [`CCIP_NUM_TIDS-1:0]        timeout,
   input  logic [`CCIP_NUM_TIDS-1:0]        unsolicited,
   output logic                             error_valid,
   output sniff_code_pkg::sniff_code_t      error_code
);

   import sniff_code_pkg::*;

   sniff_code_t code_nxt;

   // First hit in code order wins
   always_comb begin
      code_nxt = SNIFF_NO_ERROR;
      if (c0_flags.invalid_reqtype)     code_nxt = C0_INVALID_REQTYPE;
      else if (c0_flags.overflow)       code_nxt = C0_OVERFLOW;
      else if (c0_flags.req_3cl)        code_nxt = C0_3CL_REQUEST;
      else if (c0_flags.addralign_2)    code_nxt = C0_ADDRALIGN_2;
      else if (c0_flags.addralign_4)    code_nxt = C0_ADDRALIGN_4;
      else if (c1_flags.invalid_reqtype) code_nxt = C1_INVALID_REQTYPE;
      else if (c1_flags.overflow)       code_nxt = C1_OVERFLOW;
      else if (c1_flags.req_3cl)        code_nxt = C1_3CL_REQUEST;
      else if (c1_flags.sop_not_set)    code_nxt = C1_SOP_NOT_SET;
      else if (c1_flags.addralign_2)    code_nxt = C1_ADDRALIGN_2;
      else if (c1_flags.addralign_4)    code_nxt = C1_ADDRALIGN_4;
      else if (c1_flags.sop_set_mcl)    code_nxt = C1_SOP_SET_MCL;
      else if (c1_flags.unexp_vcsel)    code_nxt = C1_UNEXP_VCSEL;
      else if (c1_flags.unexp_reqtype)  code_nxt = C1_UNEXP_REQTYPE;
      else if (c1_flags.unexp_addr)     code_nxt = C1_UNEXP_ADDR;
      else if (c1_flags.wrfence_in_mcl) code_nxt = C1_WRFENCE_IN_MCL;
      // Any slot counts, TID is not reported
      else if (|unsolicited)            code_nxt = MMIO_RDRSP_UNSOLICITED;
      else if (|timeout)                code_nxt = MMIO_RDRSP_TIMEOUT;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         error_valid <= 1'b0;
         error_code  <= SNIFF_NO_ERROR;
      end else begin
         error_valid <= (code_nxt != SNIFF_NO_ERROR);
         error_code  <= code_nxt;
      end
   end

endmodule

`default_nettype wire

/* verification/ccip_sniffer_chk.sv */
//####################
// Sniffer output checks
// Reset behavior and code legality on the error outputs
//####################

`timescale 1ns/1ps
`default_nettype none

module ccip_sniffer_chk (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        error_valid,
   input sniff_code_pkg::sniff_code_t error_code
);

   import sniff_code_pkg::*;

   // Quiet while in reset and on the first edge after it
   reset_quiet: assert property (@(posedge clk) !rst_n |=> !error_valid)
      else $error("error_valid high during or right after reset");

   // Valid and code agree
   code_matches_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (error_code == SNIFF_NO_ERROR) == !error_valid)
      else $error("error_code and error_valid disagree");

   // Top of the code space is the MMIO timeout
   code_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      error_code <= MMIO_RDRSP_TIMEOUT)
      else $error("error_code outside the listed codes");

endmodule

bind ccip_sniffer ccip_sniffer_chk u_chk (
   .clk(clk),
   .rst_n(rst_n),
   .error_valid(error_valid),
   .error_code(error_code)
);

`default_nettype wire

/* verification/ccip_sniffer_tb.sv */
//####################
// CCI-P sniffer testbench
// Directed and LFSR driven traffic on C0, C1 and MMIO,
// checked each clock against a cycle model
//####################

`timescale 1ns/1ps
`default_nettype none

`include "ccip_sniff_macros.svh"

module ccip_sniffer_tb;

   import ccip_hdr_pkg::*;
   import sniff_code_pkg::*;

   localparam int PLANNED_CYCLES = 1100;
   localparam int NTID = `CCIP_NUM_TIDS;

   logic clk = 1'b0;
   logic rst_n = 1'b0;
   logic c0_valid = 1'b0, c0_full = 1'b0;
   t_ccip_req c0_req_type = RDLINE_S;
   t_ccip_cl_len c0_cl_len = CL_LEN_1;
   t_ccip_addr c0_address = '0;
   logic c1_valid = 1'b0, c1_sop = 1'b0, c1_full = 1'b0;
   t_ccip_req c1_req_type = WRLINE_I;
   t_ccip_cl_len c1_cl_len = CL_LEN_1;
   t_ccip_vc c1_vc_sel = VC_VA;
   t_ccip_addr c1_address = '0;
   logic mmio_req_valid = 1'b0, mmio_rsp_valid = 1'b0;
   logic [`CCIP_TID_WIDTH-1:0] mmio_req_tid = '0, mmio_rsp_tid = '0;
   logic error_valid;
   sniff_code_t error_code;

   // Values for the next clock, applied by tick
   logic n_c0_valid = 1'b0, n_c0_full = 1'b0;
   t_ccip_req n_c0_req = RDLINE_S;
   t_ccip_cl_len n_c0_len = CL_LEN_1;
   t_ccip_addr n_c0_addr = '0;
   logic n_c1_valid = 1'b0, n_c1_sop = 1'b0, n_c1_full = 1'b0;
   t_ccip_req n_c1_req = WRLINE_I;
   t_ccip_cl_len n_c1_len = CL_LEN_1;
   t_ccip_vc n_c1_vc = VC_VA;
   t_ccip_addr n_c1_addr = '0;
   logic n_req_valid = 1'b0, n_rsp_valid = 1'b0;
   logic [`CCIP_TID_WIDTH-1:0] n_req_tid = '0, n_rsp_tid = '0;

   logic [15:0] lfsr = 16'd23;

   // Model state
   int m_state = 0;
   logic [1:0] m_base_low2 = '0;
   t_ccip_vc m_base_vc = VC_VA;
   t_ccip_req m_base_req = WRLINE_I;
   t_ccip_cl_len m_base_len = CL_LEN_1;
   logic m_active [NTID];
   int m_age [NTID];
   sniff_code_t exp_code = SNIFF_NO_ERROR;

   ccip_sniffer UUT (
      .clk, .rst_n, .c0_valid, .c0_req_type, .c0_cl_len, .c0_address, .c0_full,
      .c1_valid, .c1_sop, .c1_req_type, .c1_cl_len, .c1_vc_sel, .c1_address, .c1_full,
      .mmio_req_valid, .mmio_req_tid, .mmio_rsp_valid, .mmio_rsp_tid,
      .error_valid, .error_code
   );

   always #4 clk = ~clk;

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v = {v[62:0], fb};
      end
      return v;
   endfunction

   // Mostly legal types, some raw encodings
   function automatic t_ccip_req pick_req();
      logic [2:0] sel;
      sel = 3'(rand_bits(3));
      case (sel)
         3'd0: return RDLINE_S;
         3'd1: return RDLINE_I;
         3'd2: return WRLINE_M;
         3'd3: return WRLINE_I;
         3'd4: return WRFENCE;
         default: return t_ccip_req'(rand_bits(4));
      endcase
   endfunction

   task automatic tick(input int n = 1);
      repeat (n) begin
         @(posedge clk);
         c0_valid <= n_c0_valid;
         c0_req_type <= n_c0_req;
         c0_cl_len <= n_c0_len;
         c0_address <= n_c0_addr;
         c0_full <= n_c0_full;
         c1_valid <= n_c1_valid;
         c1_sop <= n_c1_sop;
         c1_req_type <= n_c1_req;
         c1_cl_len <= n_c1_len;
         c1_vc_sel <= n_c1_vc;
         c1_address <= n_c1_addr;
         c1_full <= n_c1_full;
         mmio_req_valid <= n_req_valid;
         mmio_req_tid <= n_req_tid;
         mmio_rsp_valid <= n_rsp_valid;
         mmio_rsp_tid <= n_rsp_tid;
         n_c0_valid = 1'b0;
         n_c1_valid = 1'b0;
         n_req_valid = 1'b0;
         n_rsp_valid = 1'b0;
         n_c0_full = 1'b0;
         n_c1_full = 1'b0;
      end
   endtask

   task automatic set_c0(input t_ccip_req req, input t_ccip_cl_len len,
                         input t_ccip_addr addr, input logic full);
      n_c0_valid = 1'b1;
      n_c0_req = req;
      n_c0_len = len;
      n_c0_addr = addr;
      n_c0_full = full;
   endtask

   task automatic set_c1(input logic sop, input t_ccip_req req, input t_ccip_cl_len len,
                         input t_ccip_vc vc, input t_ccip_addr addr);
      n_c1_valid = 1'b1;
      n_c1_sop = sop;
      n_c1_req = req;
      n_c1_len = len;
      n_c1_vc = vc;
      n_c1_addr = addr;
   endtask

   // Whole burst, one beat per clock
   task automatic write_burst(input int lines, input t_ccip_addr base, input t_ccip_vc vc);
      t_ccip_cl_len len;
      len = t_ccip_cl_len'(lines - 1);
      for (int b = 0; b < lines; b++) begin
         set_c1(b == 0, WRLINE_M, len, vc, base + t_ccip_addr'(b));
         tick();
      end
   endtask

   // Cycle model, reads inputs settled since the last edge
   always @(posedge clk) begin : model
      logic [18:0] hit;
      logic wr, fence, rd, push, pop;
      if (!rst_n) begin
         m_state = 0;
         for (int t = 0; t < NTID; t++) begin
            m_active[t] = 1'b0;
            m_age[t] = 0;
         end
         exp_code = SNIFF_NO_ERROR;
      end else begin
         hit = '0;
         rd = (c0_req_type == RDLINE_S) || (c0_req_type == RDLINE_I);
         if (c0_valid) begin
            hit[1] = !rd;
            hit[2] = c0_full;
            if (rd) begin
               hit[3] = (c0_cl_len == CL_LEN_3);
               hit[4] = (c0_cl_len == CL_LEN_2) && c0_address[0];
               hit[5] = (c0_cl_len == CL_LEN_4) && (c0_address[1:0] != 2'b00);
            end
         end
         wr = (c1_req_type == WRLINE_M) || (c1_req_type == WRLINE_I);
         fence = (c1_req_type == WRFENCE);
         if (c1_valid) begin
            hit[6] = !wr && !fence;
            hit[7] = c1_full;
            if (m_state == 0 && wr) begin
               hit[9] = !c1_sop;
               hit[8] = (c1_cl_len == CL_LEN_3);
               hit[10] = (c1_cl_len == CL_LEN_2) && c1_address[0];
               hit[11] = (c1_cl_len == CL_LEN_4) && (c1_address[1:0] != 2'b00);
            end else if (m_state != 0) begin
               if (wr) begin
                  hit[12] = c1_sop;
                  hit[13] = (c1_vc_sel != m_base_vc);
                  hit[14] = (c1_req_type != m_base_req);
                  hit[15] = (c1_address[1:0] != 2'(m_base_low2 + 2'(m_state)));
               end
               hit[16] = fence;
            end
         end
         for (int t = 0; t < NTID; t++) begin
            if (mmio_rsp_valid && mmio_rsp_tid == t && !m_active[t]) hit[17] = 1'b1;
            if (m_active[t] && m_age[t] == `MMIO_RSP_TIMEOUT) hit[18] = 1'b1;
         end
         exp_code = SNIFF_NO_ERROR;
         for (int i = 18; i >= 1; i--) begin
            if (hit[i]) exp_code = sniff_code_t'(i);
         end

         // Burst advance on write beats only
         if (c1_valid && wr) begin
            if (m_state == 0) begin
               if (c1_sop && (c1_cl_len == CL_LEN_2 || c1_cl_len == CL_LEN_4)) begin
                  m_state = 1;
                  m_base_low2 = c1_address[1:0];
                  m_base_vc = c1_vc_sel;
                  m_base_req = c1_req_type;
                  m_base_len = c1_cl_len;
               end
            end else if ((m_state == 1 && m_base_len == CL_LEN_2) || m_state == 3) begin
               m_state = 0;
            end else begin
               m_state = m_state + 1;
            end
         end

         // Slot age counts edges since the request
         for (int t = 0; t < NTID; t++) begin
            push = mmio_req_valid && mmio_req_tid == t;
            pop = mmio_rsp_valid && mmio_rsp_tid == t;
            if (push) begin
               m_active[t] = 1'b1;
               m_age[t] = 0;
            end else begin
               if (m_active[t]) m_age[t] = m_age[t] + 1;
               if (pop) m_active[t] = 1'b0;
            end
         end
      end
   end

   always @(negedge clk) begin
      assert (error_code === exp_code && error_valid === (exp_code != SNIFF_NO_ERROR))
      else begin
         $display("Fail at %0t ns: expected code %0d, got code %0d valid %0b",
                  $time, exp_code, error_code, error_valid);
         $display("Errors found");
         $fatal(1, "Output mismatch");
      end
   end

   initial begin : watchdog
      #(PLANNED_CYCLES * 8 + 400);
      $display("Errors found");
      $fatal(1, "Watchdog expired before the tests finished");
   end

   initial begin : stimulus
      t_ccip_addr c1_base;

      // Faulty beats while in reset must stay unreported
      set_c0(WRLINE_M, CL_LEN_3, 42'h1, 1'b1);
      n_rsp_valid = 1'b1;
      n_rsp_tid = 4'd2;
      tick();
      tick();
      rst_n <= 1'b1;
      tick(2);

      // Legal reads and writes, fences between bursts
      set_c0(RDLINE_S, CL_LEN_1, 42'h3, 1'b0);
      tick();
      set_c0(RDLINE_I, CL_LEN_2, 42'h10, 1'b0);
      tick();
      set_c0(RDLINE_S, CL_LEN_4, 42'h24, 1'b0);
      tick();
      set_c1(1'b1, WRLINE_I, CL_LEN_1, VC_VL0, 42'h7);
      tick();
      write_burst(2, 42'h40, VC_VH0);
      set_c1(1'b0, WRFENCE, CL_LEN_1, VC_VA, 42'h0);
      tick();
      write_burst(4, 42'h80, VC_VH1);
      write_burst(4, 42'h84, VC_VA);
      tick(2);

      // C0 faults
      set_c0(t_ccip_req'(4'h3), CL_LEN_1, 42'h0, 1'b0);
      tick();
      set_c0(WRLINE_M, CL_LEN_3, 42'h1, 1'b1);
      tick();
      set_c0(RDLINE_S, CL_LEN_3, 42'h0, 1'b0);
      tick();
      set_c0(RDLINE_S, CL_LEN_2, 42'h5, 1'b0);
      tick();
      set_c0(RDLINE_I, CL_LEN_4, 42'h6, 1'b0);
      tick();
      set_c0(RDLINE_I, CL_LEN_1, 42'h0, 1'b1);
      tick(2);

      // C1 faults, first beats then burst beats
      set_c1(1'b0, WRLINE_M, CL_LEN_2, VC_VA, 42'h8);
      tick();
      set_c1(1'b1, WRLINE_M, CL_LEN_3, VC_VA, 42'h8);
      tick();
      set_c1(1'b1, WRLINE_M, CL_LEN_4, VC_VA, 42'h9);
      tick();
      set_c1(1'b1, WRLINE_M, CL_LEN_4, VC_VA, 42'h2);
      tick();
      // VC change alone on the third beat
      set_c1(1'b0, WRLINE_M, CL_LEN_4, VC_VH0, 42'h3);
      tick();
      set_c1(1'b0, WRFENCE, CL_LEN_1, VC_VA, 42'h0);
      tick();
      // Request type change alone on the last beat
      set_c1(1'b0, WRLINE_I, CL_LEN_4, VC_VA, 42'h4);
      tick();
      set_c1(1'b0, t_ccip_req'(4'hF), CL_LEN_4, VC_VA, 42'h5);
      tick();
      set_c1(1'b0, WRLINE_M, CL_LEN_4, VC_VA, 42'h7);
      tick();
      // 2-line burst repeating its first line
      set_c1(1'b1, WRLINE_M, CL_LEN_2, VC_VL0, 42'hA);
      tick();
      set_c1(1'b0, WRLINE_M, CL_LEN_2, VC_VL0, 42'hA);
      tick();
      tick(2);

      // MMIO answered, then one left to time out
      n_req_valid = 1'b1;
      n_req_tid = 4'd3;
      tick(10);
      n_rsp_valid = 1'b1;
      n_rsp_tid = 4'd3;
      tick();
      n_req_valid = 1'b1;
      n_req_tid = 4'd5;
      tick(`MMIO_RSP_TIMEOUT + 6);
      n_rsp_valid = 1'b1;
      n_rsp_tid = 4'd5;
      tick();

      // Response with nothing outstanding
      n_rsp_valid = 1'b1;
      n_rsp_tid = 4'd9;
      tick(3);

      // Random mixed traffic
      c1_base = '0;
      for (int c = 0; c < 600; c++) begin
         if (rand_bits(2) != 2'b00) begin
            set_c0(pick_req(), t_ccip_cl_len'(rand_bits(2)), t_ccip_addr'(rand_bits(42)),
                   rand_bits(3) == 3'd0);
         end
         if (rand_bits(2) != 2'b00) begin
            c1_base = c1_base + 42'd1;
            set_c1(rand_bits(2) == 2'b00, pick_req(), t_ccip_cl_len'(rand_bits(2)),
                   (rand_bits(3) == 3'd0) ? VC_VH0 : VC_VL0,
                   (rand_bits(3) == 3'd0) ? t_ccip_addr'(rand_bits(42)) : c1_base);
            n_c1_full = (rand_bits(4) == 4'd0);
         end
         if (rand_bits(3) == 3'd0) begin
            n_req_valid = 1'b1;
            n_req_tid = 4'(rand_bits(4));
         end
         if (rand_bits(3) == 3'd0) begin
            n_rsp_valid = 1'b1;
            n_rsp_tid = 4'(rand_bits(4));
         end
         tick();
      end
      tick(3);

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire
